//--- verilog/lsuPkg.sv
package lsuPkg;

    // Width of store data, load data and response data
    localparam int dataWidth = 32;

    localparam int tagWidth = 4;

    // Byte counts 1, 2 and 4 need three bits
    localparam int bytesWidth = 3;

    // --------------------------------------------------
    // Request operation
    // --------------------------------------------------

    // Loads come first, stores last
    typedef enum logic [2:0] {
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opSb,
        opSh,
        opSw
    } memOp;

    typedef logic [tagWidth-1:0] tagT;

endpackage

//--- verilog/loadStoreQueue.sv
`timescale 1ns/100ps

module loadStoreQueue #(
    parameter int addrWidth  = 8,
    parameter int queueDepth = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         inValid,
    input  lsuPkg::memOp                 inOp,
    input  logic [addrWidth-1:0]         inAddr,
    input  logic [lsuPkg::dataWidth-1:0] inData,
    input  lsuPkg::tagT                  inTag,
    input  logic                         headReady,
    output logic                         inReady,
    output logic                         headValid,
    output lsuPkg::memOp                 headOp,
    output logic [addrWidth-1:0]         headAddr,
    output logic [lsuPkg::dataWidth-1:0] headData,
    output lsuPkg::tagT                  headTag
);
    import lsuPkg::*;

    localparam int ptrWidth = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntWidth = $clog2(queueDepth + 1);

    memOp                 opMem   [queueDepth];
    logic [addrWidth-1:0] addrMem [queueDepth];
    logic [dataWidth-1:0] dataMem [queueDepth];
    tagT                  tagMem  [queueDepth];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [cntWidth-1:0] count;
    logic                push;
    logic                pop;

    // Pointers wrap at queueDepth, which need not be a power of two
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(queueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign inReady   = (count != cntWidth'(queueDepth));
    assign headValid = (count != '0);
    assign push      = inValid && inReady;
    assign pop       = headValid && headReady;

    assign headOp   = opMem[rdPtr];
    assign headAddr = addrMem[rdPtr];
    assign headData = dataMem[rdPtr];
    assign headTag  = tagMem[rdPtr];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A write during flush lands in a slot that the reset pointers treat as empty
    always_ff @(posedge clk) begin
        if (push) begin
            opMem[wrPtr]   <= inOp;
            addrMem[wrPtr] <= inAddr;
            dataMem[wrPtr] <= inData;
            tagMem[wrPtr]  <= inTag;
        end
    end

endmodule

//--- verilog/memAccessUnit.sv
`timescale 1ns/100ps

module memAccessUnit #(
    parameter int addrWidth = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          headValid,
    input  lsuPkg::memOp                  headOp,
    input  logic [addrWidth-1:0]          headAddr,
    input  logic [lsuPkg::dataWidth-1:0]  headData,
    input  lsuPkg::tagT                   headTag,
    input  logic                          memDone,
    input  logic [lsuPkg::dataWidth-1:0]  memRdata,
    input  logic                          resReady,
    output logic                          headReady,
    output logic                          memStart,
    output logic                          memWrite,
    output logic [addrWidth-1:0]          memAddr,
    output logic [lsuPkg::bytesWidth-1:0] memBytes,
    output logic [lsuPkg::dataWidth-1:0]  memWdata,
    output logic                          resValid,
    output lsuPkg::tagT                   resTag,
    output logic [lsuPkg::dataWidth-1:0]  resData
);
    import lsuPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stWaitMem,
        stHoldRes
    } unitState;

    unitState             state;
    memOp                 reqOp;
    logic [addrWidth-1:0] reqAddr;
    logic [dataWidth-1:0] reqData;
    tagT                  reqTag;
    logic                 discard;
    logic [dataWidth-1:0] loadData;

    // A request is never taken on a flush cycle, so it cannot slip past the flush
    assign headReady = (state == stIdle) && !flush;
    assign resValid  = (state == stHoldRes);

    assign memAddr  = reqAddr;
    assign memWdata = reqData;
    assign memWrite = (reqOp == opSb) || (reqOp == opSh) || (reqOp == opSw);

    always_comb begin
        case (reqOp)
            opLb, opLbu, opSb: memBytes = bytesWidth'(1);
            opLh, opLhu, opSh: memBytes = bytesWidth'(2);
            default:           memBytes = bytesWidth'(4);
        endcase
    end

    // --------------------------------------------------
    // Load data extension
    // --------------------------------------------------

    always_comb begin
        case (reqOp)
            opLb:    loadData = {{24{memRdata[7]}}, memRdata[7:0]};
            opLbu:   loadData = {24'd0, memRdata[7:0]};
            opLh:    loadData = {{16{memRdata[15]}}, memRdata[15:0]};
            opLhu:   loadData = {16'd0, memRdata[15:0]};
            opLw:    loadData = memRdata;
            default: loadData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stIdle;
            memStart <= 1'b0;
            discard  <= 1'b0;
        end else begin
            memStart <= headValid && headReady;
            case (state)
                stIdle: begin
                    discard <= 1'b0;
                    if (headValid && headReady) begin
                        state <= stWaitMem;
                    end
                end
                stWaitMem: begin
                    // The RAM access still runs to the end, only its result is lost
                    if (flush) begin
                        discard <= 1'b1;
                    end
                    if (memDone) begin
                        state <= (discard || flush) ? stIdle : stHoldRes;
                    end
                end
                default: begin
                    if (flush || resReady) begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (headValid && headReady) begin
            reqOp   <= headOp;
            reqAddr <= headAddr;
            reqData <= headData;
            reqTag  <= headTag;
        end
        if (state == stWaitMem && memDone) begin
            resData <= loadData;
            resTag  <= reqTag;
        end
    end

endmodule

//--- verilog/memController.sv
`timescale 1ns/100ps

module memController #(
    parameter int addrWidth = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          memStart,
    input  logic                          memWrite,
    input  logic [addrWidth-1:0]          memAddr,
    input  logic [lsuPkg::bytesWidth-1:0] memBytes,
    input  logic [lsuPkg::dataWidth-1:0]  memWdata,
    input  logic [7:0]                    ramRdata,
    output logic                          memDone,
    output logic [lsuPkg::dataWidth-1:0]  memRdata,
    output logic                          ramWe,
    output logic [addrWidth-1:0]          ramAddr,
    output logic [7:0]                    ramWdata
);
    import lsuPkg::*;

    logic                  active;
    logic                  phase;
    logic                  writeReg;
    logic [1:0]            byteIdx;
    logic [bytesWidth-1:0] bytesReg;
    logic [addrWidth-1:0]  curAddr;
    logic [dataWidth-1:0]  wdataReg;
    logic [dataWidth-1:0]  rdataReg;
    logic                  lastByte;

    assign lastByte = ({1'b0, byteIdx} + 3'd1) == bytesReg;

    // Phase 0 presents the address, phase 1 captures the read byte or writes
    assign ramAddr  = curAddr;
    assign ramWe    = active && phase && writeReg;
    assign ramWdata = wdataReg[byteIdx*8 +: 8];
    assign memRdata = rdataReg;

    // --------------------------------------------------
    // Byte sequencer
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            phase   <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= 1'b0;
            if (!active) begin
                if (memStart) begin
                    active <= 1'b1;
                    phase  <= 1'b0;
                end
            end else if (!phase) begin
                phase <= 1'b1;
            end else begin
                phase <= 1'b0;
                if (lastByte) begin
                    active  <= 1'b0;
                    memDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && memStart) begin
            writeReg <= memWrite;
            bytesReg <= memBytes;
            curAddr  <= memAddr;
            wdataReg <= memWdata;
            byteIdx  <= 2'd0;
            // Bytes past the access width stay zero
            rdataReg <= '0;
        end else if (active && phase) begin
            // Address wraps naturally at the top of the RAM
            curAddr <= curAddr + 1'b1;
            byteIdx <= byteIdx + 1'b1;
            if (!writeReg) begin
                rdataReg[byteIdx*8 +: 8] <= ramRdata;
            end
        end
    end

endmodule

//--- verilog/dataRam.sv
`timescale 1ns/100ps

module dataRam #(
    parameter int addrWidth = 8
) (
    input  logic                 clk,
    input  logic                 ramWe,
    input  logic [addrWidth-1:0] ramAddr,
    input  logic [7:0]           ramWdata,
    output logic [7:0]           ramRdata
);

    logic [7:0] mem [2**addrWidth];

    // Read returns the old byte when a write hits the same address
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
        ramRdata <= mem[ramAddr];
    end

endmodule

//--- verilog/lsuTop.sv
`timescale 1ns/100ps

module lsuTop #(
    parameter int addrWidth  = 8,
    parameter int queueDepth = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         inValid,
    input  lsuPkg::memOp                 inOp,
    input  logic [addrWidth-1:0]         inAddr,
    input  logic [lsuPkg::dataWidth-1:0] inData,
    input  lsuPkg::tagT                  inTag,
    input  logic                         resReady,
    output logic                         inReady,
    output logic                         resValid,
    output lsuPkg::tagT                  resTag,
    output logic [lsuPkg::dataWidth-1:0] resData
);
    import lsuPkg::*;

    logic                  headValid;
    logic                  headReady;
    memOp                  headOp;
    logic [addrWidth-1:0]  headAddr;
    logic [dataWidth-1:0]  headData;
    tagT                   headTag;

    logic                  memStart;
    logic                  memWrite;
    logic [addrWidth-1:0]  memAddr;
    logic [bytesWidth-1:0] memBytes;
    logic [dataWidth-1:0]  memWdata;
    logic                  memDone;
    logic [dataWidth-1:0]  memRdata;

    logic                  ramWe;
    logic [addrWidth-1:0]  ramAddr;
    logic [7:0]            ramWdata;
    logic [7:0]            ramRdata;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------

    loadStoreQueue #(
        .addrWidth  (addrWidth),
        .queueDepth (queueDepth)
    ) uQueue (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .inValid   (inValid),
        .inOp      (inOp),
        .inAddr    (inAddr),
        .inData    (inData),
        .inTag     (inTag),
        .headReady (headReady),
        .inReady   (inReady),
        .headValid (headValid),
        .headOp    (headOp),
        .headAddr  (headAddr),
        .headData  (headData),
        .headTag   (headTag)
    );

    // --------------------------------------------------
    // Access unit, controller and RAM
    // --------------------------------------------------

    memAccessUnit #(
        .addrWidth (addrWidth)
    ) uAccess (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .headValid (headValid),
        .headOp    (headOp),
        .headAddr  (headAddr),
        .headData  (headData),
        .headTag   (headTag),
        .memDone   (memDone),
        .memRdata  (memRdata),
        .resReady  (resReady),
        .headReady (headReady),
        .memStart  (memStart),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memBytes  (memBytes),
        .memWdata  (memWdata),
        .resValid  (resValid),
        .resTag    (resTag),
        .resData   (resData)
    );

    memController #(
        .addrWidth (addrWidth)
    ) uCtrl (
        .clk      (clk),
        .reset    (reset),
        .memStart (memStart),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memBytes (memBytes),
        .memWdata (memWdata),
        .ramRdata (ramRdata),
        .memDone  (memDone),
        .memRdata (memRdata),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata)
    );

    dataRam #(
        .addrWidth (addrWidth)
    ) uRam (
        .clk      (clk),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

//--- bench/lsuTb.sv
`timescale 1ns/100ps

module lsuTb;
    import lsuPkg::*;

    localparam int addrWidth  = 8;
    localparam int queueDepth = 4;
    localparam int lineWords  = 6;
    localparam int maxLines   = 64;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 flush;
    logic                 inValid;
    memOp                 inOp;
    logic [addrWidth-1:0] inAddr;
    logic [dataWidth-1:0] inData;
    tagT                  inTag;
    logic                 resReady;
    logic                 inReady;
    logic                 resValid;
    tagT                  resTag;
    logic [dataWidth-1:0] resData;

    logic [31:0] stimMem [lineWords*maxLines];
    int          lineCount;
    int          lineIdx;
    int          base;
    int unsigned seedValue;
    logic        stimLoaded = 1'b0;

    // Expected responses in request order, filled on each accepted request
    tagT                  expTag  [$];
    logic [dataWidth-1:0] expData [$];
    int                   expLine [$];
    logic [dataWidth-1:0] curExpect;
    int                   curLine;

    tagT                  tagWant;
    logic [dataWidth-1:0] dataWant;
    int                   lineNo;
    logic                 holdCheck = 1'b0;
    tagT                  heldTag;
    logic [dataWidth-1:0] heldData;
    logic                 sawFull = 1'b0;
    int                   stallLeft = 0;

    lsuTop #(
        .addrWidth  (addrWidth),
        .queueDepth (queueDepth)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .inValid  (inValid),
        .inOp     (inOp),
        .inAddr   (inAddr),
        .inData   (inData),
        .inTag    (inTag),
        .resReady (resReady),
        .inReady  (inReady),
        .resValid (resValid),
        .resTag   (resTag),
        .resData  (resData)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic sendRequest(input int idx);
        int at;
        at        = idx * lineWords;
        inOp      = memOp'(stimMem[at+1][2:0]);
        inTag     = stimMem[at+2][tagWidth-1:0];
        inAddr    = stimMem[at+3][addrWidth-1:0];
        inData    = stimMem[at+4];
        curExpect = stimMem[at+5];
        curLine   = idx + 1;
        inValid   = 1'b1;
        while (!inReady) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic pulseFlush();
        inValid = 1'b0;
        flush   = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // A discarded access still runs to the end inside the controller
    task automatic waitController();
        while (u_dut.uCtrl.active) begin
            @(negedge clk);
        end
    endtask

    // --------------------------------------------------
    // Driver
    // --------------------------------------------------

    initial begin
        reset    = 1'b1;
        flush    = 1'b0;
        inValid  = 1'b0;
        inOp     = opLb;
        inAddr   = '0;
        inData   = '0;
        inTag    = '0;
        resReady = 1'b0;
        seedValue = $urandom(32'h86b2);
        for (int i = 0; i < lineWords * maxLines; i++) begin
            stimMem[i] = '1;
        end
        $readmemh("bench/lsuStim.txt", stimMem);
        lineCount = 0;
        while (lineCount < maxLines && stimMem[lineCount*lineWords] <= 1) begin
            lineCount++;
        end
        if (lineCount == 0) begin
            $display("No stimulus lines could be read from bench/lsuStim.txt");
            $display("Errors found");
            $fatal(1, "Empty stimulus");
        end else begin
            stimLoaded = 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            checkValue("reset resValid", 32'd0, {31'd0, resValid});
            checkValue("reset inReady", 32'd1, {31'd0, inReady});
            for (lineIdx = 0; lineIdx < lineCount; lineIdx++) begin
                base = lineIdx * lineWords;
                if (stimMem[base][0]) begin
                    pulseFlush();
                    waitController();
                end
                sendRequest(lineIdx);
            end
            inValid = 1'b0;
            while (expData.size() != 0 || resValid || u_dut.uCtrl.active) begin
                @(negedge clk);
            end
            checkValue("queue full seen", 32'd1, {31'd0, sawFull});
            $display("No errors");
            $finish;
        end
    end

    // Random back-pressure with occasional long stalls
    always @(negedge clk) begin
        if (stallLeft != 0) begin
            resReady  = 1'b0;
            stallLeft = stallLeft - 1;
        end else if ($urandom % 8 == 0) begin
            resReady  = 1'b0;
            stallLeft = 4 + $urandom % 12;
        end else begin
            resReady = ($urandom % 4) != 0;
        end
    end

    // --------------------------------------------------
    // Receiver and scoreboard
    // --------------------------------------------------

    always @(posedge clk) begin
        if (!reset) begin
            if (holdCheck) begin
                checkValue("held resValid", 32'd1, {31'd0, resValid});
                checkValue("held resTag", {28'd0, heldTag}, {28'd0, resTag});
                checkValue("held resData", heldData, resData);
            end
            holdCheck = resValid && !resReady && !flush;
            heldTag   = resTag;
            heldData  = resData;
            if (inValid && !inReady) begin
                sawFull = 1'b1;
            end
            if (resValid && resReady) begin
                if (expData.size() == 0) begin
                    $display("Response with tag %h came out with no request outstanding", resTag);
                    $display("Errors found");
                    $fatal(1, "Unexpected response");
                end else begin
                    tagWant  = expTag.pop_front();
                    dataWant = expData.pop_front();
                    lineNo   = expLine.pop_front();
                    checkValue($sformatf("line %0d tag", lineNo), {28'd0, tagWant},
                               {28'd0, resTag});
                    checkValue($sformatf("line %0d data", lineNo), dataWant, resData);
                end
            end
            // Everything still outstanding at a flush is dropped
            if (flush) begin
                expTag.delete();
                expData.delete();
                expLine.delete();
            end else if (inValid && inReady) begin
                expTag.push_back(inTag);
                expData.push_back(curExpect);
                expLine.push_back(curLine);
            end
        end
    end

    initial begin
        wait (stimLoaded);
        repeat (40 * lineCount + 50) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", 40 * lineCount + 50);
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- bench/lsuStim.txt
// Columns: flush op tag addr wdata expect, all hex
// op: 0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw
0 7 1 10 8badf00d 00000000
0 4 2 10 00000000 8badf00d
0 0 3 13 00000000 ffffff8b
0 1 4 13 00000000 0000008b
0 2 5 12 00000000 ffff8bad
0 3 6 12 00000000 00008bad
0 2 7 10 00000000 fffff00d
0 6 8 20 00001234 00000000
0 2 9 20 00000000 00001234
0 6 a 22 ffffa5c7 00000000
0 0 b 22 00000000 ffffffc7
0 4 c 20 00000000 a5c71234
0 5 d 21 0000007f 00000000
0 0 e 21 00000000 0000007f
0 4 f 20 00000000 a5c77f34
// Word across the top of the RAM
0 7 0 fe 11223344 00000000
0 4 1 fe 00000000 11223344
0 3 2 ff 00000000 00002233
0 0 3 01 00000000 00000011
0 2 4 ff 00000000 00002233
// Store starts before the second flush and must still land
1 7 5 40 cafe0001 00000000
0 4 6 10 00000000 8badf00d
0 4 7 20 00000000 a5c77f34
1 4 8 40 00000000 cafe0001
0 5 9 41 000000ee 00000000
0 4 a 40 00000000 cafeee01
0 1 b 43 00000000 000000ca
0 0 c 43 00000000 ffffffca
0 6 d 42 00008001 00000000
0 2 e 42 00000000 ffff8001
0 3 f 42 00000000 00008001
0 4 0 40 00000000 8001ee01

//--- compile.f
verilog/lsuPkg.sv
verilog/loadStoreQueue.sv
verilog/memAccessUnit.sv
verilog/memController.sv
verilog/dataRam.sv
verilog/lsuTop.sv
bench/lsuTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --timescale 1ns/100ps -f compile.f \
        --top-module lsuTb -o lsuSim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsuSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Errors found" "$logFile"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation PASSED"
exit 0
